// File: exu_top.f
+incdir+design
design/exu_pkg.sv
design/exu_ctrl.sv
design/exu_regfile.sv
design/exu_alu.sv
design/exu_wb.sv
design/exu_top.sv
dv/exu_tb.sv

// File: dv/exu_tb.sv
/* execute slice testbench
   lfsr driven issue stream checked against a register file model */

`default_nettype none

`include "exu_defs.svh"

module exu_tb;

    import exu_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 400;
    localparam int CYCLE_LIMIT  = NUM_INSTR * 8 + 200;

    // stream flavours
    localparam int M_RESET = 0;
    localparam int M_OPS   = 1;
    localparam int M_CHAIN = 2;
    localparam int M_BP    = 3;
    localparam int M_FLUSH = 4;
    localparam int M_X0    = 5;

    logic                       clk;
    logic                       rst_n_i;
    logic                       flush_i;
    logic                       issue_valid_i;
    alu_op_e                    issue_op_i;
    logic [`REG_ADDR_WIDTH-1:0] issue_rs1_i;
    logic [`REG_ADDR_WIDTH-1:0] issue_rs2_i;
    logic [`REG_ADDR_WIDTH-1:0] issue_rd_i;
    logic [`XLEN-1:0]           issue_imm_i;
    logic                       issue_use_imm_i;
    logic [`XLEN-1:0]           issue_pc_i;
    wire                        issue_ready_o;
    wire                        retire_valid_o;
    wire  [`REG_ADDR_WIDTH-1:0] retire_rd_o;
    wire  [`XLEN-1:0]           retire_data_o;
    logic                       retire_ready_i;

    logic [31:0]                lfsr_q;
    int                         cycle_count;
    int                         err_count;
    int                         check_count;
    int                         errs_reported;
    int                         checks_reported;
    logic [`REG_ADDR_WIDTH-1:0] last_rd;

    // committed architectural state
    logic [`XLEN-1:0]           model_regs [0:`REG_NUM-1];
    // expected retirements, issue order
    logic [`REG_ADDR_WIDTH-1:0] exp_rd_q [$];
    logic [`XLEN-1:0]           exp_data_q [$];

    exu_top dut0 (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .issue_valid_i   (issue_valid_i),
        .issue_op_i      (issue_op_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_rd_i      (issue_rd_i),
        .issue_imm_i     (issue_imm_i),
        .issue_use_imm_i (issue_use_imm_i),
        .issue_pc_i      (issue_pc_i),
        .issue_ready_o   (issue_ready_o),
        .retire_valid_o  (retire_valid_o),
        .retire_rd_o     (retire_rd_o),
        .retire_data_o   (retire_data_o),
        .retire_ready_i  (retire_ready_i)
    );

    always #CLK_HALF clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, retire stream did not drain", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // n bits, one lfsr step each
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // small register set, forces dependencies
    function automatic logic [`REG_ADDR_WIDTH-1:0] pick_reg();
        case (rnd(3) % 6)
            0: return 5'd0;
            1: return 5'd1;
            2: return 5'd2;
            3: return 5'd3;
            4: return 5'd5;
            default: return 5'd7;
        endcase
    endfunction

    // shift amounts 0 and 31, sign and carry corners
    function automatic logic [`XLEN-1:0] edge_value();
        case (rnd(3))
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'h0000_001f;
            3: return 32'h7fff_ffff;
            4: return 32'h8000_0000;
            5: return 32'hffff_ffff;
            6: return 32'hffff_ffe0;
            default: return 32'h0000_0020;
        endcase
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [`XLEN-1:0] model_alu(input alu_op_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_SLL:   return a << sh;
            ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:   return a ^ b;
            ALU_SRL:   return a >> sh;
            ALU_SRA:   return $signed(a) >>> sh;
            ALU_OR:    return a | b;
            ALU_AND:   return a & b;
            ALU_LUI:   return b;
            // pc + imm and pc + 4
            ALU_AUIPC: return a + b;
            ALU_JUMP:  return a + b;
            default:   return '0;
        endcase
    endfunction

    // sources are committed here, pending rd blocks issue
    task automatic queue_expected();
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        a = model_regs[issue_rs1_i];
        b = issue_use_imm_i ? issue_imm_i : model_regs[issue_rs2_i];
        case (issue_op_i)
            ALU_LUI: begin
                b = issue_imm_i;
            end
            ALU_AUIPC: begin
                a = issue_pc_i;
                b = issue_imm_i;
            end
            ALU_JUMP: begin
                a = issue_pc_i;
                b = 32'd4;
            end
            default: begin
            end
        endcase
        exp_rd_q.push_back(issue_rd_i);
        exp_data_q.push_back(model_alu(issue_op_i, a, b));
    endtask

    task automatic check_retire(input string name);
        logic [`REG_ADDR_WIDTH-1:0] exp_rd;
        logic [`XLEN-1:0]           exp_data;
        check_count++;
        assert (exp_rd_q.size() != 0) else begin
            $display("%s: retire of x%0d with no accepted issue left", name, retire_rd_o);
            err_count++;
        end
        if (exp_rd_q.size() != 0) begin
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (retire_rd_o == exp_rd) else begin
                $display("ERR %s rd expected %0d actual %0d", name, exp_rd, retire_rd_o);
                err_count++;
            end
            assert (retire_data_o == exp_data) else begin
                $display("ERR %s data expected %h actual %h", name, exp_data, retire_data_o);
                err_count++;
            end
            // x0 never written
            if (exp_rd != '0) begin
                model_regs[exp_rd] = exp_data;
            end
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic pick_instr(input int mode);
        if (mode == M_RESET) begin
            issue_op_i      = ALU_ADD;
            issue_rs1_i     = '0;
            issue_rs2_i     = '0;
            issue_rd_i      = 5'd5;
            issue_imm_i     = '0;
            issue_use_imm_i = 1'b0;
            issue_pc_i      = '0;
        end else begin
            issue_op_i      = alu_op_e'(4'(rnd(4) % 13));
            // chain reads the previous rd
            issue_rs1_i     = (mode == M_CHAIN) ? last_rd : pick_reg();
            issue_rs2_i     = pick_reg();
            issue_rd_i      = pick_reg();
            if ((mode == M_X0) && (rnd(2) == 0)) begin
                issue_rd_i = '0;
            end
            issue_imm_i     = (rnd(1) != 0) ? edge_value() : rnd(32);
            issue_use_imm_i = (rnd(1) != 0);
            issue_pc_i      = rnd(30) << 2;
        end
        last_rd = issue_rd_i;
    endtask

    task automatic run_test(input string name, input int mode, input int count);
        int                         issued;
        logic                       pending;
        logic                       held;
        logic [`REG_ADDR_WIDTH-1:0] held_rd;
        logic [`XLEN-1:0]           held_data;
        issued  = 0;
        pending = 1'b0;
        held    = 1'b0;
        while ((issued < count) || pending || (exp_rd_q.size() != 0)) begin
            @(posedge clk);
            #2;
            // fields stay put until accepted
            if (!pending && (issued < count)) begin
                pick_instr(mode);
                pending = 1'b1;
            end
            issue_valid_i  = pending;
            flush_i        = (mode == M_FLUSH) && (rnd(4) == 0);
            retire_ready_i = (mode != M_BP) || (rnd(3) >= 3);
            // settle, sample just before the edge
            #(2 * CLK_HALF - 4);
            if (held) begin
                assert (retire_valid_o && (retire_data_o == held_data) &&
                        (retire_rd_o == held_rd)) else begin
                    $display("%s: retire entry changed while retire_ready_i was low", name);
                    err_count++;
                end
            end
            held      = retire_valid_o && !retire_ready_i;
            held_rd   = retire_rd_o;
            held_data = retire_data_o;
            if (issue_valid_i && issue_ready_o) begin
                // flushed issue leaves no retire
                if (!flush_i) begin
                    queue_expected();
                end
                pending = 1'b0;
                issued++;
            end
            if (retire_valid_o && retire_ready_i) begin
                check_retire(name);
            end
        end
        $display("test %-14s %0d checks, %0d errors", name,
                 check_count - checks_reported, err_count - errs_reported);
        checks_reported = check_count;
        errs_reported   = err_count;
    endtask

    initial begin
        clk             = 1'b0;
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        issue_valid_i   = 1'b0;
        issue_op_i      = ALU_ADD;
        issue_rs1_i     = '0;
        issue_rs2_i     = '0;
        issue_rd_i      = '0;
        issue_imm_i     = '0;
        issue_use_imm_i = 1'b0;
        issue_pc_i      = '0;
        retire_ready_i  = 1'b1;
        lfsr_q          = 32'hde4e_1c18;
        cycle_count     = 0;
        err_count       = 0;
        check_count     = 0;
        errs_reported   = 0;
        checks_reported = 0;
        last_rd         = '0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end

        // nothing retires under reset
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #2;
            check_count++;
            assert (!retire_valid_o) else begin
                $display("retire_valid_o high during reset");
                err_count++;
            end
        end
        rst_n_i = 1'b1;
        #(2 * CLK_HALF - 4);
        check_count++;
        assert (!retire_valid_o && issue_ready_o) else begin
            $display("wrong retire_valid_o or issue_ready_o in first cycle after reset");
            err_count++;
        end

        run_test("reset_add", M_RESET, 1);
        run_test("all_opcodes", M_OPS, 140);
        run_test("dep_chain", M_CHAIN, 70);
        run_test("backpressure", M_BP, 70);
        run_test("flush", M_FLUSH, 60);
        run_test("x0_dest", M_X0, 59);

        $display("summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/exu_top.sv
/* integer execute slice
   issue control, register file, alu and writeback */

`default_nettype none

`include "exu_defs.svh"

module exu_top (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        flush_i,

    // issue port
    input  wire                        issue_valid_i,
    input  exu_pkg::alu_op_e           issue_op_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  issue_rs1_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  issue_rs2_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  issue_rd_i,
    input  wire [`XLEN-1:0]            issue_imm_i,
    input  wire                        issue_use_imm_i,
    input  wire [`XLEN-1:0]            issue_pc_i,
    output wire                        issue_ready_o,

    // retire port
    output wire                        retire_valid_o,
    output wire [`REG_ADDR_WIDTH-1:0]  retire_rd_o,
    output wire [`XLEN-1:0]            retire_data_o,
    input  wire                        retire_ready_i
);

    // register file read
    wire [`REG_ADDR_WIDTH-1:0] rs1_addr;
    wire [`REG_ADDR_WIDTH-1:0] rs2_addr;
    wire [`XLEN-1:0]           rs1_data;
    wire [`XLEN-1:0]           rs2_data;

    // control to alu
    wire                       req_alu;
    wire [`ALU_OP_WIDTH-1:0]   op_info;
    wire [`XLEN-1:0]           op1;
    wire [`XLEN-1:0]           op2;
    wire [`REG_ADDR_WIDTH-1:0] rd;

    // alu to writeback
    wire                       alu_stall;
    wire                       alu_we;
    wire [`XLEN-1:0]           alu_result;
    wire [`REG_ADDR_WIDTH-1:0] alu_rd;
    wire                       wb_ready;

    // writeback to register file and hazard check
    wire                       rf_we;
    wire [`REG_ADDR_WIDTH-1:0] rf_waddr;
    wire [`XLEN-1:0]           rf_wdata;
    wire                       wb_pend_valid;
    wire [`REG_ADDR_WIDTH-1:0] wb_pend_rd;

    exu_ctrl u_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_op_i      (issue_op_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_rd_i      (issue_rd_i),
        .issue_imm_i     (issue_imm_i),
        .issue_use_imm_i (issue_use_imm_i),
        .issue_pc_i      (issue_pc_i),
        .issue_ready_o   (issue_ready_o),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .alu_stall_i     (alu_stall),
        .alu_pend_we_i   (alu_we),
        .alu_pend_rd_i   (alu_rd),
        .wb_pend_valid_i (wb_pend_valid),
        .wb_pend_rd_i    (wb_pend_rd),
        .req_alu_o       (req_alu),
        .op_info_o       (op_info),
        .op1_o           (op1),
        .op2_o           (op2),
        .rd_o            (rd)
    );

    exu_regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    exu_alu u_alu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_alu_i     (req_alu),
        .flush_i       (flush_i),
        .alu_op1_i     (op1),
        .alu_op2_i     (op2),
        .alu_op_info_i (op_info),
        .alu_rd_i      (rd),
        .wb_ready_i    (wb_ready),
        .alu_stall_o   (alu_stall),
        .result_o      (alu_result),
        .reg_we_o      (alu_we),
        .reg_waddr_o   (alu_rd)
    );

    exu_wb u_wb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .alu_we_i       (alu_we),
        .alu_result_i   (alu_result),
        .alu_rd_i       (alu_rd),
        .wb_ready_o     (wb_ready),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_ready_i (retire_ready_i),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .pend_valid_o   (wb_pend_valid),
        .pend_rd_o      (wb_pend_rd)
    );

endmodule

`default_nettype wire

// File: design/exu_wb.sv
/* writeback stage
   one-entry hold, retire handshake and register file write */

`default_nettype none

`include "exu_defs.svh"

module exu_wb (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        alu_we_i,
    input  wire [`XLEN-1:0]            alu_result_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  alu_rd_i,
    output logic                       wb_ready_o,
    output logic                       retire_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [`XLEN-1:0]           retire_data_o,
    input  wire                        retire_ready_i,
    output logic                       rf_we_o,
    output logic [`REG_ADDR_WIDTH-1:0] rf_waddr_o,
    output logic [`XLEN-1:0]           rf_wdata_o,
    output logic                       pend_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] pend_rd_o
);

    import exu_pkg::*;

    wb_state_e state_q;
    logic      retire_fire;
    logic      load;

    assign retire_valid_o = (state_q == WB_FULL);
    assign retire_fire    = retire_valid_o & retire_ready_i;
    // free now, or freed by this cycle's retire
    assign wb_ready_o     = (state_q == WB_EMPTY) | retire_fire;
    assign load           = alu_we_i & wb_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= WB_EMPTY;
        end else if (load) begin
            state_q <= WB_FULL;
        end else if (retire_fire) begin
            state_q <= WB_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            retire_rd_o   <= alu_rd_i;
            retire_data_o <= alu_result_i;
        end
    end

    // register file commits on the retire edge, x0 filtered there
    assign rf_we_o    = retire_fire;
    assign rf_waddr_o = retire_rd_o;
    assign rf_wdata_o = retire_data_o;

    // held entry seen by the hazard check
    assign pend_valid_o = retire_valid_o;
    assign pend_rd_o    = retire_rd_o;

    a_retire_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_valid_o && !retire_ready_i |=>
            retire_valid_o && $stable(retire_data_o) && $stable(retire_rd_o));

endmodule

`default_nettype wire

// File: design/exu_alu.sv
/* integer alu with registered output
   shared shifter and adder, ready/stall handshake toward writeback */

`default_nettype none

`include "exu_defs.svh"

module exu_alu (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        req_alu_i,
    input  wire                        flush_i,
    input  wire [`XLEN-1:0]            alu_op1_i,
    input  wire [`XLEN-1:0]            alu_op2_i,
    input  wire [`ALU_OP_WIDTH-1:0]    alu_op_info_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  alu_rd_i,
    input  wire                        wb_ready_i,
    output logic                       alu_stall_o,
    output logic [`XLEN-1:0]           result_o,
    output logic                       reg_we_o,
    output logic [`REG_ADDR_WIDTH-1:0] reg_waddr_o
);

    import exu_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    // mirror a word, msb to lsb
    function automatic logic [`XLEN-1:0] bit_rev(input logic [`XLEN-1:0] v);
        logic [`XLEN-1:0] r;
        for (int i = 0; i < `XLEN; i++) begin
            r[i] = v[`XLEN-1-i];
        end
        return r;
    endfunction

    // op groups
    logic op_shift;
    logic op_right;
    logic op_cmp;
    logic op_adder;
    logic op_inv;
    assign op_right = alu_op_info_i[ALU_SRL] | alu_op_info_i[ALU_SRA];
    assign op_shift = alu_op_info_i[ALU_SLL] | op_right;
    assign op_cmp   = alu_op_info_i[ALU_SLT] | alu_op_info_i[ALU_SLTU];
    assign op_inv   = alu_op_info_i[ALU_SUB] | op_cmp;
    assign op_adder = alu_op_info_i[ALU_ADD] | op_inv |
                      alu_op_info_i[ALU_AUIPC] | alu_op_info_i[ALU_JUMP];

    ////////////////////////////////////////
    // shifter, left only
    ////////////////////////////////////////

    logic [`XLEN-1:0] sh_in;
    logic [SHW-1:0]   sh_amt;
    logic [`XLEN-1:0] sh_out;
    logic [`XLEN-1:0] srl_res;
    logic [`XLEN-1:0] sra_mask;
    logic [`XLEN-1:0] sra_res;

    // right shifts go through reversed input
    assign sh_in    = {`XLEN{op_shift}} & (op_right ? bit_rev(alu_op1_i) : alu_op1_i);
    assign sh_amt   = {SHW{op_shift}} & alu_op2_i[SHW-1:0];
    assign sh_out   = sh_in << sh_amt;
    assign srl_res  = bit_rev(sh_out);
    // vacated top bits get the sign
    assign sra_mask = ~({`XLEN{1'b1}} >> sh_amt);
    assign sra_res  = srl_res | ({`XLEN{alu_op1_i[`XLEN-1]}} & sra_mask);

    ////////////////////////////////////////
    // adder, also compare and pc math
    ////////////////////////////////////////

    logic [`XLEN-1:0] add_a;
    logic [`XLEN-1:0] add_b;
    logic [`XLEN:0]   add_sum;
    logic             lt_s;
    logic             lt_u;

    // subtract as a + ~b + 1
    assign add_a   = {`XLEN{op_adder}} & alu_op1_i;
    assign add_b   = {`XLEN{op_adder}} & (op_inv ? ~alu_op2_i : alu_op2_i);
    assign add_sum = {1'b0, add_a} + {1'b0, add_b} + (`XLEN+1)'(op_inv);

    // signs differ, the negative one is smaller
    assign lt_s = (alu_op1_i[`XLEN-1] != alu_op2_i[`XLEN-1]) ?
                  alu_op1_i[`XLEN-1] : add_sum[`XLEN-1];
    // no carry out means a borrow
    assign lt_u = ~add_sum[`XLEN];

    ////////////////////////////////////////
    // result select
    ////////////////////////////////////////

    logic [`XLEN-1:0] alu_res;
    assign alu_res =
        ({`XLEN{op_adder & ~op_cmp}}       & add_sum[`XLEN-1:0]) |
        ({`XLEN{alu_op_info_i[ALU_SLT]}}  & `XLEN'(lt_s)) |
        ({`XLEN{alu_op_info_i[ALU_SLTU]}} & `XLEN'(lt_u)) |
        ({`XLEN{alu_op_info_i[ALU_SLL]}}  & sh_out) |
        ({`XLEN{alu_op_info_i[ALU_SRL]}}  & srl_res) |
        ({`XLEN{alu_op_info_i[ALU_SRA]}}  & sra_res) |
        ({`XLEN{alu_op_info_i[ALU_XOR]}}  & (alu_op1_i ^ alu_op2_i)) |
        ({`XLEN{alu_op_info_i[ALU_OR]}}   & (alu_op1_i | alu_op2_i)) |
        ({`XLEN{alu_op_info_i[ALU_AND]}}  & (alu_op1_i & alu_op2_i)) |
        ({`XLEN{alu_op_info_i[ALU_LUI]}}  & alu_op2_i);

    ////////////////////////////////////////
    // output register and handshake
    ////////////////////////////////////////

    logic update;

    // load when writeback takes the entry or the entry is a bubble
    assign update      = wb_ready_i | ~reg_we_o;
    assign alu_stall_o = reg_we_o & ~wb_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_we_o <= 1'b0;
        end else if (update) begin
            // flushed issue becomes a bubble
            reg_we_o <= req_alu_i & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            result_o    <= alu_res;
            reg_waddr_o <= alu_rd_i;
        end
    end

    // held entry stays put until writeback accepts it
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        alu_stall_o |=> $stable(result_o) && $stable(reg_waddr_o) && reg_we_o);

    a_op_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_alu_i |-> $onehot0(alu_op_info_i));

endmodule

`default_nettype wire

// File: design/exu_regfile.sv
/* integer register file
   two combinational reads, one write, x0 tied to zero */

`default_nettype none

`include "exu_defs.svh"

module exu_regfile (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  raddr1_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  raddr2_i,
    output logic [`XLEN-1:0]           rdata1_o,
    output logic [`XLEN-1:0]           rdata2_o,
    input  wire                        we_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  waddr_i,
    input  wire [`XLEN-1:0]            wdata_i
);

    // x1 .. x31, x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_NUM-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            // writes to x0 dropped
            regs[waddr_i] <= wdata_i;
        end
    end

    // no write bypass, new value visible the cycle after
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: design/exu_ctrl.sv
/* issue control
   hazard check, operand select and opcode to one-hot decode */

`default_nettype none

`include "exu_defs.svh"

module exu_ctrl (
    input  wire                        clk,
    input  wire                        rst_n_i,

    // issue port
    input  wire                        issue_valid_i,
    input  exu_pkg::alu_op_e           issue_op_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  issue_rs1_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  issue_rs2_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  issue_rd_i,
    input  wire [`XLEN-1:0]            issue_imm_i,
    input  wire                        issue_use_imm_i,
    input  wire [`XLEN-1:0]            issue_pc_i,
    output logic                       issue_ready_o,

    // register file read
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr_o,
    input  wire [`XLEN-1:0]            rs1_data_i,
    input  wire [`XLEN-1:0]            rs2_data_i,

    // pending writes downstream
    input  wire                        alu_stall_i,
    input  wire                        alu_pend_we_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  alu_pend_rd_i,
    input  wire                        wb_pend_valid_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  wb_pend_rd_i,

    // request toward alu
    output logic                       req_alu_o,
    output logic [`ALU_OP_WIDTH-1:0]   op_info_o,
    output logic [`XLEN-1:0]           op1_o,
    output logic [`XLEN-1:0]           op2_o,
    output logic [`REG_ADDR_WIDTH-1:0] rd_o
);

    import exu_pkg::*;

    logic rs1_hit;
    logic rs2_hit;
    logic hazard;

    // sources read straight from the register file
    assign rs1_addr_o = issue_rs1_i;
    assign rs2_addr_o = issue_rs2_i;

    ////////////////////////////////////////
    // hazard check
    ////////////////////////////////////////

    // wb_pend_valid_i is writeback sitting in WB_FULL
    // x0 never creates a dependency
    assign rs1_hit = (issue_rs1_i != '0) &&
                     ((alu_pend_we_i && (issue_rs1_i == alu_pend_rd_i)) ||
                      (wb_pend_valid_i && (issue_rs1_i == wb_pend_rd_i)));
    assign rs2_hit = (issue_rs2_i != '0) &&
                     ((alu_pend_we_i && (issue_rs2_i == alu_pend_rd_i)) ||
                      (wb_pend_valid_i && (issue_rs2_i == wb_pend_rd_i)));
    assign hazard  = rs1_hit | rs2_hit;

    // no forwarding so a dependent op waits for the retire
    // alu output stall also blocks issue
    assign issue_ready_o = ~hazard & ~alu_stall_i;
    assign req_alu_o     = issue_valid_i & issue_ready_o;

    ////////////////////////////////////////
    // decode and operand select
    ////////////////////////////////////////

    // enum value picks the one-hot bit
    assign op_info_o = `ALU_OP_WIDTH'(1) << issue_op_i;
    assign rd_o      = issue_rd_i;

    always_comb begin
        // default covers the reg/reg and reg/imm ops
        op1_o = rs1_data_i;
        op2_o = issue_use_imm_i ? issue_imm_i : rs2_data_i;
        case (issue_op_i)
            ALU_LUI: begin
                op2_o = issue_imm_i;
            end
            ALU_AUIPC: begin
                op1_o = issue_pc_i;
                op2_o = issue_imm_i;
            end
            // link value pc + 4
            ALU_JUMP: begin
                op1_o = issue_pc_i;
                op2_o = `XLEN'(4);
            end
            default: begin
            end
        endcase
    end

    // held issue keeps its fields until accepted
    a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue_valid_i && !issue_ready_o |=> issue_valid_i
            && $stable(issue_op_i) && $stable(issue_rs1_i) && $stable(issue_rs2_i)
            && $stable(issue_rd_i) && $stable(issue_imm_i)
            && $stable(issue_use_imm_i) && $stable(issue_pc_i));

endmodule

`default_nettype wire

// File: design/exu_pkg.sv
/* execute slice types
   opcode and writeback state encodings */

`default_nettype none

package exu_pkg;

    // alu opcode, the value is also the one-hot bit position
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,
        ALU_AUIPC = 4'd11,
        ALU_JUMP  = 4'd12
    } alu_op_e;

    // writeback holding stage occupancy
    typedef enum logic {
        WB_EMPTY = 1'b0,
        WB_FULL  = 1'b1
    } wb_state_e;

endpackage

`default_nettype wire

// File: design/exu_defs.svh
/* execute slice parameters
   data width, register file geometry and one-hot op width */

`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data path width
`define XLEN 32

// register number width
`define REG_ADDR_WIDTH 5

// architectural register count, x0 included
`define REG_NUM 32

// one-hot op vector width
// one bit per alu_op_e member, bit index is the enum value
`define ALU_OP_WIDTH 13

`endif
